//--- rtl/endstop_guard.sv
`timescale 1ns/1ps
`include "motion_defs.svh"

module endstop_guard (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`MOTION_ENDSTOPS-1:0]                     endstop,
    input  motion_pkg::endstop_opt_t [`MOTION_ENDSTOPS-1:0] opt,
    input  logic                                            unlock,
    output logic [`MOTION_ENDSTOPS-1:0]                     endstop_state,
    output logic                                            abort
);

    logic [`MOTION_SYNC_STAGES-1:0][`MOTION_ENDSTOPS-1:0] sync;
    logic [`MOTION_ENDSTOPS-1:0]                          hit_vec;
    logic                                                 hit;

    // Pins are asynchronous to clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync <= '0;
        end else begin
            sync[0] <= endstop;
            for (int s = 1; s < `MOTION_SYNC_STAGES; s++)
                sync[s] <= sync[s-1];
        end
    end

    assign endstop_state = sync[`MOTION_SYNC_STAGES-1];

    always_comb begin
        for (int i = 0; i < `MOTION_ENDSTOPS; i++) begin
            hit_vec[i] = opt[i].abort_enabled &&
                         (endstop_state[i] == opt[i].abort_polarity);
        end
    end

    assign hit = |hit_vec;

    // Sticky until unlocked and kept set by a held endstop
    always_ff @(posedge clk) begin
        if (!rst_n)
            abort <= 1'b0;
        else if (hit)
            abort <= 1'b1;
        else if (unlock)
            abort <= 1'b0;
    end

endmodule

//--- rtl/motion_defs.svh
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

`define MOTION_DATA_W       32
`define MOTION_ADDR_W       3
`define MOTION_AXES         3
`define MOTION_MOTORS       4
`define MOTION_ENDSTOPS     4
`define MOTION_SYNC_STAGES  2

// Register map
`define REG_PRE_N        3'd0
`define REG_PULSE_N      3'd1
`define REG_POST_N       3'd2
`define REG_MOTOR_CFG    3'd3
`define REG_ENDSTOP_OPT  3'd4
`define REG_UNLOCK       3'd5  // strobe only

`endif

//--- rtl/motion_pkg.sv
`include "motion_defs.svh"

package motion_pkg;

    typedef struct packed {
        logic [`MOTION_ADDR_W-1:0] addr;
        logic [`MOTION_DATA_W-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [1:0] axis;  // 3 is discarded
        logic       dir;
    } step_cmd_t;

    typedef struct packed {
        logic step;
        logic dir;
    } axis_drive_t;

    typedef struct packed {
        logic [`MOTION_DATA_W-1:0] pre_n;
        logic [`MOTION_DATA_W-1:0] pulse_n;
        logic [`MOTION_DATA_W-1:0] post_n;
    } step_timing_t;

    // One nibble per motor with enable in bit 0
    typedef struct packed {
        logic       invert_dir;
        logic [1:0] axis_sel;
        logic       enable;
    } motor_cfg_t;

    typedef struct packed {
        logic abort_enabled;
        logic abort_polarity;
    } endstop_opt_t;

endpackage

//--- rtl/motion_top.sv
`timescale 1ns/1ps
`include "motion_defs.svh"

module motion_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_wr_valid,
    input  motion_pkg::reg_write_t      reg_wr,
    input  logic                        cmd_valid,
    input  motion_pkg::step_cmd_t       cmd,
    output logic                        cmd_ready,
    input  logic [`MOTION_ENDSTOPS-1:0] endstop,
    output logic [`MOTION_MOTORS-1:0]   motor_step,
    output logic [`MOTION_MOTORS-1:0]   motor_dir,
    output logic [`MOTION_MOTORS-1:0]   motor_enable,
    output logic [`MOTION_ENDSTOPS-1:0] endstop_state,
    output logic                        abort
);

    motion_pkg::step_timing_t                        timing;
    motion_pkg::motor_cfg_t   [`MOTION_MOTORS-1:0]   motor_cfg;
    motion_pkg::endstop_opt_t [`MOTION_ENDSTOPS-1:0] endstop_opt;
    motion_pkg::axis_drive_t  [`MOTION_AXES-1:0]     axis_drive;
    logic                                            unlock;
    logic [`MOTION_AXES-1:0]                         axis_idle;
    logic [`MOTION_AXES:0]                           ready_sel;
    logic                                            cmd_fire;

    reg_bank u_reg_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr       (reg_wr),
        .timing       (timing),
        .motor_cfg    (motor_cfg),
        .endstop_opt  (endstop_opt),
        .unlock       (unlock)
    );

    // Axis index 3 is always ready and goes nowhere
    assign ready_sel = {1'b1, axis_idle};
    assign cmd_ready = ready_sel[cmd.axis];
    assign cmd_fire  = cmd_valid && cmd_ready;

    for (genvar a = 0; a < `MOTION_AXES; a++) begin : g_axis
        step_pulse_gen u_gen (
            .clk       (clk),
            .rst_n     (rst_n),
            .start     (cmd_fire && (cmd.axis == a)),
            .start_dir (cmd.dir),
            .timing    (timing),
            .abort     (abort),
            .idle      (axis_idle[a]),
            .drive     (axis_drive[a])
        );
    end

    endstop_guard u_guard (
        .clk           (clk),
        .rst_n         (rst_n),
        .endstop       (endstop),
        .opt           (endstop_opt),
        .unlock        (unlock),
        .endstop_state (endstop_state),
        .abort         (abort)
    );

    motor_router u_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .axis         (axis_drive),
        .cfg          (motor_cfg),
        .motor_step   (motor_step),
        .motor_dir    (motor_dir),
        .motor_enable (motor_enable)
    );

endmodule

//--- rtl/motor_router.sv
`timescale 1ns/1ps
`include "motion_defs.svh"

module motor_router (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  motion_pkg::axis_drive_t [`MOTION_AXES-1:0]   axis,
    input  motion_pkg::motor_cfg_t  [`MOTION_MOTORS-1:0] cfg,
    output logic [`MOTION_MOTORS-1:0]                    motor_step,
    output logic [`MOTION_MOTORS-1:0]                    motor_dir,
    output logic [`MOTION_MOTORS-1:0]                    motor_enable
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            motor_step   <= '0;
            motor_dir    <= '0;
            motor_enable <= '1;  // drivers off
        end else begin
            for (int m = 0; m < `MOTION_MOTORS; m++) begin
                motor_enable[m] <= ~cfg[m].enable;  // active low pin
                if (cfg[m].axis_sel < `MOTION_AXES) begin
                    motor_step[m] <= axis[cfg[m].axis_sel].step;
                    motor_dir[m]  <= axis[cfg[m].axis_sel].dir ^ cfg[m].invert_dir;
                end else begin
                    // Unrouted motor
                    motor_step[m] <= 1'b0;
                    motor_dir[m]  <= cfg[m].invert_dir;
                end
            end
        end
    end

endmodule

//--- rtl/reg_bank.sv
`timescale 1ns/1ps
`include "motion_defs.svh"

module reg_bank (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            reg_wr_valid,
    input  motion_pkg::reg_write_t                          reg_wr,
    output motion_pkg::step_timing_t                        timing,
    output motion_pkg::motor_cfg_t   [`MOTION_MOTORS-1:0]   motor_cfg,
    output motion_pkg::endstop_opt_t [`MOTION_ENDSTOPS-1:0] endstop_opt,
    output logic                                            unlock
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing      <= '0;
            motor_cfg   <= '0;
            endstop_opt <= '0;
            unlock      <= 1'b0;
        end else begin
            unlock <= 1'b0;  // single cycle pulse
            if (reg_wr_valid) begin
                case (reg_wr.addr)
                    `REG_PRE_N: begin
                        timing.pre_n <= reg_wr.data;
                    end
                    `REG_PULSE_N: begin
                        timing.pulse_n <= reg_wr.data;
                    end
                    `REG_POST_N: begin
                        timing.post_n <= reg_wr.data;
                    end
                    `REG_MOTOR_CFG: begin
                        // Motor 0 sits in the low nibble
                        motor_cfg <= reg_wr.data[$bits(motor_cfg)-1:0];
                    end
                    `REG_ENDSTOP_OPT: begin
                        endstop_opt <= reg_wr.data[$bits(endstop_opt)-1:0];
                    end
                    `REG_UNLOCK: begin
                        unlock <= 1'b1;  // data ignored
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/step_pulse_gen.sv
`timescale 1ns/1ps
`include "motion_defs.svh"

module step_pulse_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     start_dir,
    input  motion_pkg::step_timing_t timing,
    input  logic                     abort,
    output logic                     idle,
    output motion_pkg::axis_drive_t  drive
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE,
        ST_PULSE,
        ST_POST
    } state_t;

    state_t                    state;
    logic [`MOTION_DATA_W-1:0] cnt;

    // Zero counts behave as one cycle
    function automatic logic [`MOTION_DATA_W-1:0] at_least_one(
        input logic [`MOTION_DATA_W-1:0] n
    );
        return (n == '0) ? `MOTION_DATA_W'(1) : n;
    endfunction

    // Abort frees the command stream while a running sequence still finishes
    assign idle = (state == ST_IDLE) || abort;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            drive <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start && !abort) begin
                        drive.dir <= start_dir;
                        cnt       <= at_least_one(timing.pre_n);
                        state     <= ST_PRE;
                    end
                end
                ST_PRE: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == `MOTION_DATA_W'(1)) begin
                        drive.step <= 1'b1;
                        cnt        <= at_least_one(timing.pulse_n);
                        state      <= ST_PULSE;
                    end
                end
                ST_PULSE: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == `MOTION_DATA_W'(1)) begin
                        drive.step <= 1'b0;
                        cnt        <= at_least_one(timing.post_n);
                        state      <= ST_POST;
                    end
                end
                default: begin  // recovery
                    cnt <= cnt - 1'b1;
                    if (cnt == `MOTION_DATA_W'(1))
                        state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sim/motion_checker.sv
`timescale 1ns/1ps

module motion_checker (
    input logic       clk,
    input logic       cmd_valid,
    input logic       cmd_ready,
    input logic [3:0] motor_step,
    input logic [3:0] motor_dir,
    input logic [3:0] motor_enable,
    input logic [3:0] endstop_state,
    input logic       abort
);

    int         pulses [4];
    int         width [4];
    int         run [4];
    logic       dir_at_rise [4];
    logic [3:0] step_q = '0;
    int         accepted = 0;
    int         test_id = 0;
    int         test_errors = 0;
    int         passed = 0;
    int         failed = 0;

    // Sample mid-cycle while outputs are stable
    always @(negedge clk) begin
        for (int m = 0; m < 4; m++) begin
            if (motor_step[m] && !step_q[m]) begin
                pulses[m]++;
                dir_at_rise[m] = motor_dir[m];
                run[m] = 1;
            end else if (motor_step[m]) begin
                run[m]++;
            end else if (step_q[m]) begin
                width[m] = run[m];  // pulse just ended
            end
        end
        step_q = motor_step;
        if (cmd_valid && cmd_ready)
            accepted++;  // transfers on the next edge
    end

    task automatic finish_test();
        if (test_id != 0) begin
            if (test_errors == 0) begin
                $display("test %0d passed, %0d commands accepted", test_id, accepted);
                passed++;
            end else begin
                $display("test %0d failed with %0d errors", test_id, test_errors);
                failed++;
            end
        end
        test_id = 0;
    endtask

    task automatic begin_test(input int id);
        finish_test();
        test_id     = id;
        test_errors = 0;
        accepted    = 0;
        for (int m = 0; m < 4; m++) begin
            pulses[m] = 0;
            width[m]  = 0;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pulses(input logic [3:0] mask, input int count, input int w,
                                input logic d);
        for (int m = 0; m < 4; m++) begin
            if (mask[m]) begin
                compare($sformatf("motor_step[%0d] count", m), count, pulses[m]);
                if (count > 0) begin
                    compare($sformatf("motor_step[%0d] width", m), w, width[m]);
                    compare($sformatf("motor_dir[%0d]", m), d, dir_at_rise[m]);
                end
            end
        end
    endtask

    task automatic check_guard(input logic a, input logic [3:0] st);
        compare("abort", a, abort);
        compare("endstop_state", st, endstop_state);
    endtask

    task automatic check_enable(input logic [3:0] en);
        compare("motor_enable", en, motor_enable);
    endtask

    task automatic report_counts(output int fails);
        finish_test();
        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        fails = failed;
    endtask

endmodule

//--- sim/motion_tb.sv
`timescale 1ns/1ps

module motion_tb;

    localparam int TIMEOUT = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   reg_wr_valid;
    motion_pkg::reg_write_t reg_wr;
    logic                   cmd_valid;
    motion_pkg::step_cmd_t  cmd;
    logic                   cmd_ready;
    logic [3:0]             endstop;
    logic [3:0]             motor_step;
    logic [3:0]             motor_dir;
    logic [3:0]             motor_enable;
    logic [3:0]             endstop_state;
    logic                   abort;
    int                     run_errors;

    motion_top i_dut (.*);

    motion_checker i_chk (.*);

    always #2 clk = ~clk;

    function automatic logic cond_met(input byte op, input logic [3:0] v);
        case (op)
            "B":     return abort == v[0];
            "S":     return endstop_state == v;
            default: return cmd_ready;  // idle flag of cmd.axis
        endcase
    endfunction

    // Hex fields that follow each operation
    function automatic int field_count(input byte op);
        case (op)
            "T", "E", "Q", "B", "S", "N": return 1;
            "W", "C", "A":                return 2;
            "P":                          return 4;
            default:                      return -1;
        endcase
    endfunction

    task automatic wait_until(input byte op, input logic [3:0] v);
        int n;
        n = 0;
        @(negedge clk);
        while (!cond_met(op, v) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cond_met(op, v)) begin
            $display("Timeout at %0t ns: condition %c %0h never became true", $time, op, v);
            run_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        reg_wr_valid = 1'b1;
        reg_wr.addr  = addr;
        reg_wr.data  = data;
        next_cycle();
        reg_wr_valid = 1'b0;
    endtask

    task automatic send_cmd(input logic [1:0] axis, input logic dir);
        cmd_valid = 1'b1;
        cmd.axis  = axis;
        cmd.dir   = dir;
        wait_until("Q", 0);
        next_cycle();  // handshake edge
        cmd_valid = 1'b0;
    endtask

    initial begin
        int                 fd;
        int                 rc;
        int                 fails;
        logic [7:0]         op;
        logic [31:0]        a, b, c, d;
        logic [8*128-1:0]   rest;
        clk          = 1'b0;
        rst_n        = 1'b0;
        reg_wr_valid = 1'b0;
        reg_wr       = '0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        endstop      = '0;
        run_errors   = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("sim/motion_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/motion_tests.txt");
            run_errors++;
        end
        while (run_errors == 0 && $fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": rc = $fgets(rest, fd);
                "T": begin
                    rc = $fscanf(fd, "%h", a);
                    i_chk.begin_test(a);
                end
                "W": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    write_reg(a[2:0], b);
                end
                "C": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    send_cmd(a[1:0], b[0]);
                end
                "E": begin
                    rc = $fscanf(fd, "%h", a);
                    endstop = a[3:0];
                    next_cycle();
                end
                "Q": begin
                    rc = $fscanf(fd, "%h", a);
                    cmd.axis = a[1:0];
                    wait_until("Q", 0);
                    repeat (2) @(posedge clk);  // router stage and last pulse edge
                    next_cycle();
                end
                "B", "S": begin
                    rc = $fscanf(fd, "%h", a);
                    wait_until(op, a[3:0]);
                    next_cycle();
                end
                "P": begin
                    rc = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    i_chk.check_pulses(a[3:0], b, c, d[0]);
                end
                "A": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    i_chk.check_guard(a[0], b[3:0]);
                end
                "N": begin
                    rc = $fscanf(fd, "%h", a);
                    i_chk.check_enable(a[3:0]);
                end
                default: begin
                    $display("Unknown operation '%c' in the test file", op);
                    run_errors++;
                end
            endcase
            if (field_count(op) > 0 && rc != field_count(op)) begin
                $display("Missing fields after operation '%c' in the test file", op);
                run_errors++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        i_chk.report_counts(fails);
        if (fails == 0 && run_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sim/motion_tests.txt
# Op and hex fields. W addr data | C axis dir | E pins | T test_id
# Waits Q axis_idle, B abort, S endstop_state. Checks P motor_mask count width dir, A abort state, N enables
T 1
Q 0
A 0 0
N f
P f 0 0 0
W 3 1901
Q 0
N 2
T 2
W 1 5
C 0 1
Q 0
P b 1 5 1
P 4 1 5 0
T 3
W 3 7531
C 1 0
C 2 1
Q 2
P 9 0 0 0
P 2 1 5 0
P 4 1 5 1
T 4
W 0 2
W 2 3
C 0 0
C 0 0
C 0 0
C 0 0
Q 0
P 1 4 5 0
P 8 0 0 0
T 5
W 4 c
E 2
B 1
A 1 2
C 0 1
C 1 1
Q 0
P f 0 0 0
E 0
S 0
W 5 0
B 0
A 0 0
C 0 1
Q 0
P 1 1 5 1

//--- verilog.f
+incdir+rtl
rtl/motion_pkg.sv
rtl/reg_bank.sv
rtl/step_pulse_gen.sv
rtl/endstop_guard.sv
rtl/motor_router.sv
rtl/motion_top.sv
sim/motion_checker.sv
sim/motion_tb.sv
